// File: alu_pipe_top.f
common/alu_pipe_pkg.sv
hdl/pipe_ctrl.sv
hdl/op_decode.sv
hdl/alu_execute.sv
hdl/alu_pipe_top.sv
verification/alu_pipe_tb.sv

// File: verification/alu_pipe_tb.sv
`default_nettype none

module alu_pipe_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD      = 10;
  localparam int RESET_CYCLES    = 4;
  localparam int DATA_W          = alu_pipe_pkg::DATA_W;
  localparam int N_RR            = 300;
  localparam int N_RI            = 200;
  localparam int N_BP            = 200;
  localparam int N_SB            = 200;
  localparam int N_FL            = 200;
  // Cycle budget per item allows for back-pressure and stalls
  localparam int CYCLES_PER_ITEM = 4;
  localparam int STIM_CYCLES     = RESET_CYCLES + 20 +
                                   CYCLES_PER_ITEM * (N_RR + N_RI + N_BP + N_SB + N_FL);

  logic                   clk;
  logic                   rst_i;
  alu_pipe_pkg::op_word_u op_i;
  logic                   op_valid_i;
  logic                   op_ready_o;
  logic [DATA_W-1:0]      res_o;
  logic                   res_valid_o;
  logic                   res_ready_i;
  logic                   flush_i;
  logic                   stall_i;
  logic                   bubble_i;

  integer            seed;
  logic [DATA_W-1:0] exp_q[$];
  int                err_value;
  int                err_unexpected;
  int                err_hold;
  int                err_ready;
  int                n_accepted;
  int                n_checked;
  logic              in_fire;
  logic              in_flush;
  logic              held_valid;
  logic [DATA_W-1:0] held_res;

  // Stimulus mix in percent per cycle
  // Operation form is 0 for register, 1 for immediate and 2 for mixed
  int pct_valid;
  int pct_ready;
  int pct_stall;
  int pct_bubble;
  int pct_flush;
  int form_mode;

  alu_pipe_top DUT (
    .clk        (clk),
    .rst_i      (rst_i),
    .op_i       (op_i),
    .op_valid_i (op_valid_i),
    .op_ready_o (op_ready_o),
    .res_o      (res_o),
    .res_valid_o(res_valid_o),
    .res_ready_i(res_ready_i),
    .flush_i    (flush_i),
    .stall_i    (stall_i),
    .bubble_i   (bubble_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(20 * STIM_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", 20 * STIM_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  function automatic bit chance(int pct);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return (r % 100) < pct;
  endfunction

  function automatic alu_pipe_pkg::op_word_u random_op();
    alu_pipe_pkg::op_word_u w;
    logic [31:0]            r1;
    logic [31:0]            r2;
    bit                     imm_form;
    r1 = $random(seed);
    r2 = $random(seed);
    if (form_mode == 2) begin
      imm_form = r2[31];
    end else begin
      imm_form = (form_mode == 1);
    end
    if (imm_form) begin
      w.ri.form   = 1'b1;
      w.ri.opcode = alu_pipe_pkg::alu_opcode_e'(r2[2:0]);
      w.ri.a      = r1[15:0];
      w.ri.ishift = r2[7:4];
      w.ri.imm    = r1[27:16];
    end else begin
      w.rr.form   = 1'b0;
      w.rr.opcode = alu_pipe_pkg::alu_opcode_e'(r2[2:0]);
      w.rr.a      = r1[15:0];
      w.rr.b      = r1[31:16];
      // Equal operands now and then for SUB and SLT corner cases
      if (r2[10:8] == 3'd0) begin
        w.rr.b = w.rr.a;
      end
    end
    return w;
  endfunction

  // Reference model of decode plus ALU from the operation word
  function automatic logic [DATA_W-1:0] expected_result(alu_pipe_pkg::op_word_u w);
    int                a;
    int                b;
    int                imm_val;
    int                sa;
    int                sb;
    logic [DATA_W-1:0] res;
    a = w.rr.a;
    if (w.rr.form) begin
      imm_val = w.ri.imm;
      if (w.ri.imm[11]) begin
        imm_val = imm_val - 4096;
      end
      b = (imm_val * (1 << w.ri.ishift)) & 32'hffff;
    end else begin
      b = w.rr.b;
    end
    sa = (a >= 32768) ? a - 65536 : a;
    sb = (b >= 32768) ? b - 65536 : b;
    case (w.rr.opcode)
      alu_pipe_pkg::OP_ADD: res = DATA_W'((a + b) & 32'hffff);
      alu_pipe_pkg::OP_SUB: res = DATA_W'((a - b) & 32'hffff);
      alu_pipe_pkg::OP_AND: res = DATA_W'(a & b);
      alu_pipe_pkg::OP_OR:  res = DATA_W'(a | b);
      alu_pipe_pkg::OP_XOR: res = DATA_W'(a ^ b);
      alu_pipe_pkg::OP_SLL: res = DATA_W'((a << (b % 16)) & 32'hffff);
      alu_pipe_pkg::OP_SRL: res = DATA_W'(a >> (b % 16));
      default:              res = (sa < sb) ? 16'd1 : 16'd0;
    endcase
    return res;
  endfunction

  task automatic set_mix(int v, int r, int s, int bu, int fl, int form);
    pct_valid  = v;
    pct_ready  = r;
    pct_stall  = s;
    pct_bubble = bu;
    pct_flush  = fl;
    form_mode  = form;
  endtask

  // Drives inputs for one cycle
  // A pending item stays until taken or flushed
  task automatic drive_cycle();
    if (!(op_valid_i && !in_fire && !in_flush)) begin
      op_valid_i = chance(pct_valid);
      op_i       = random_op();
    end
    stall_i  = chance(pct_stall);
    bubble_i = chance(pct_bubble);
    flush_i  = chance(pct_flush);
    // Consumer holds off while execute is frozen
    res_ready_i = chance(pct_ready) && !stall_i;
  endtask

  task automatic run_items(int n);
    int target;
    target = n_accepted + n;
    while (n_accepted < target) begin
      @(posedge clk);
      #1;
      drive_cycle();
    end
  endtask

  task automatic drain(int cycles_min);
    set_mix(0, 100, 0, 0, 0, 2);
    repeat (cycles_min) begin
      @(posedge clk);
      #1;
      drive_cycle();
    end
    while (op_valid_i || exp_q.size() != 0) begin
      @(posedge clk);
      #1;
      drive_cycle();
    end
  endtask

  // Outputs are stable at the falling edge and show what the next rising edge sees
  always @(negedge clk) begin : monitor
    logic [DATA_W-1:0] exp_res;
    if (!rst_i) begin
      if (held_valid) begin
        assert (res_valid_o && res_o == held_res) else begin
          $display("Fail %0t: held result expected %h, got %h with valid %b",
                   $time, held_res, res_o, res_valid_o);
          err_hold++;
        end
      end
      // Nothing outstanding means nothing on the output
      if (exp_q.size() == 0) begin
        assert (!res_valid_o) else begin
          $display("Fail %0t: res_valid_o expected 0, got 1 with no item outstanding", $time);
          err_unexpected++;
        end
      end
      if (flush_i || bubble_i) begin
        assert (!op_ready_o) else begin
          $display("Fail %0t: op_ready_o expected 0 during flush or bubble, got 1", $time);
          err_ready++;
        end
      end else if (!stall_i) begin
        assert (op_ready_o == !(exp_q.size() == 2 && !res_ready_i)) else begin
          $display("Fail %0t: op_ready_o expected %b, got %b", $time,
                   !(exp_q.size() == 2 && !res_ready_i), op_ready_o);
          err_ready++;
        end
      end else if (exp_q.size() == 2) begin
        assert (!op_ready_o) else begin
          $display("Fail %0t: op_ready_o expected 0 with a full pipeline under stall", $time);
          err_ready++;
        end
      end
      if (res_valid_o && res_ready_i && exp_q.size() != 0) begin
        exp_res = exp_q.pop_front();
        n_checked++;
        assert (res_o == exp_res) else begin
          $display("Fail %0t: result expected %h, got %h", $time, exp_res, res_o);
          err_value++;
        end
      end
      in_fire  = op_valid_i && op_ready_o;
      in_flush = flush_i;
      if (in_fire) begin
        exp_q.push_back(expected_result(op_i));
        n_accepted++;
      end
      if (flush_i) begin
        exp_q.delete();
      end
      held_valid = res_valid_o && !res_ready_i && !flush_i;
      held_res   = res_o;
    end
  end

  initial begin
    seed           = 32'hdc901858;
    err_value      = 0;
    err_unexpected = 0;
    err_hold       = 0;
    err_ready      = 0;
    n_accepted     = 0;
    n_checked      = 0;
    in_fire        = 1'b0;
    in_flush       = 1'b0;
    held_valid     = 1'b0;
    held_res       = '0;
    rst_i          = 1'b1;
    op_i           = '0;
    op_valid_i     = 1'b0;
    res_ready_i    = 1'b0;
    flush_i        = 1'b0;
    stall_i        = 1'b0;
    bubble_i       = 1'b0;
    set_mix(0, 100, 0, 0, 0, 0);
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_i = 1'b0;

    // No result may show up while idle after reset
    drain(8);

    set_mix(90, 100, 0, 0, 0, 0);
    run_items(N_RR);
    drain(2);

    set_mix(90, 100, 0, 0, 0, 1);
    run_items(N_RI);
    drain(2);

    set_mix(80, 50, 0, 0, 0, 2);
    run_items(N_BP);
    drain(2);

    set_mix(80, 80, 25, 25, 0, 2);
    run_items(N_SB);
    drain(2);

    set_mix(80, 80, 10, 10, 4, 2);
    run_items(N_FL);
    drain(2);

    assert (n_checked != 0) else begin
      $display("Error: no results were checked");
      err_unexpected++;
    end
    $display("Errors: %0d value, %0d unexpected, %0d hold, %0d ready (%0d results checked)",
             err_value, err_unexpected, err_hold, err_ready, n_checked);
    if (err_value + err_unexpected + err_hold + err_ready == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/alu_pipe_top.sv
`default_nettype none

// Two-stage ALU pipeline, decode then execute
// Latency is one or two cycles depending on DECODE_REG
module alu_pipe_top #(
  parameter bit DECODE_REG = 1'b1
) (
  input  wire                          clk,
  input  wire                          rst_i,

  // Operation input port
  input  wire alu_pipe_pkg::op_word_u  op_i,
  input  wire                          op_valid_i,
  output logic                         op_ready_o,

  // Result output port
  output logic [alu_pipe_pkg::DATA_W-1:0] res_o,
  output logic                         res_valid_o,
  input  wire                          res_ready_i,

  // Pipeline controls
  input  wire                          flush_i,
  input  wire                          stall_i,
  input  wire                          bubble_i
);

  alu_pipe_pkg::dec_ops_s dec;
  logic                   dec_valid;
  logic                   exe_ready;

  // Bubble only reaches decode
  op_decode #(
    .DECODE_REG(DECODE_REG)
  ) u_decode (
    .clk     (clk),
    .rst_i   (rst_i),
    .op_i    (op_i),
    .valid_i (op_valid_i),
    .ready_o (op_ready_o),
    .dec_o   (dec),
    .valid_o (dec_valid),
    .ready_i (exe_ready),
    .flush_i (flush_i),
    .bubble_i(bubble_i)
  );

  // Stall only reaches execute, flush goes to both stages
  alu_execute u_execute (
    .clk    (clk),
    .rst_i  (rst_i),
    .dec_i  (dec),
    .valid_i(dec_valid),
    .ready_o(exe_ready),
    .res_o  (res_o),
    .valid_o(res_valid_o),
    .ready_i(res_ready_i),
    .stall_i(stall_i),
    .flush_i(flush_i)
  );

endmodule

`default_nettype wire

// File: hdl/alu_execute.sv
`default_nettype none

// Execute stage
// Computes one of eight ALU operations and holds the result
// on the output port until the consumer takes it
module alu_execute (
  input  wire                         clk,
  input  wire                         rst_i,

  input  wire alu_pipe_pkg::dec_ops_s dec_i,
  input  wire                         valid_i,
  output logic                        ready_o,

  output logic [alu_pipe_pkg::DATA_W-1:0] res_o,
  output logic                        valid_o,
  input  wire                         ready_i,

  input  wire                         stall_i,
  input  wire                         flush_i
);

  localparam int DATA_W  = alu_pipe_pkg::DATA_W;
  localparam int SHAMT_W = $clog2(DATA_W);

  logic [DATA_W-1:0]  alu_res;
  logic [DATA_W-1:0]  res_q;
  logic [SHAMT_W-1:0] shamt;
  logic               lt_signed;
  logic               advance;

  // Shifts use only the low bits of b
  assign shamt = dec_i.b[SHAMT_W-1:0];

  assign lt_signed = $signed(dec_i.a) < $signed(dec_i.b);

  // All results wrap modulo 2^DATA_W
  always_comb begin
    case (dec_i.opcode)
      alu_pipe_pkg::OP_ADD: alu_res = dec_i.a + dec_i.b;
      alu_pipe_pkg::OP_SUB: alu_res = dec_i.a - dec_i.b;
      alu_pipe_pkg::OP_AND: alu_res = dec_i.a & dec_i.b;
      alu_pipe_pkg::OP_OR:  alu_res = dec_i.a | dec_i.b;
      alu_pipe_pkg::OP_XOR: alu_res = dec_i.a ^ dec_i.b;
      alu_pipe_pkg::OP_SLL: alu_res = dec_i.a << shamt;
      alu_pipe_pkg::OP_SRL: alu_res = dec_i.a >> shamt;
      alu_pipe_pkg::OP_SLT: alu_res = {{(DATA_W - 1){1'b0}}, lt_signed};
      default:              alu_res = '0;
    endcase
  end

  // Execute takes the external stall, never a bubble
  pipe_ctrl #(
    .SLICE_REG(1'b1)
  ) u_ctrl (
    .clk      (clk),
    .rst_i    (rst_i),
    .valid_i  (valid_i),
    .ready_i  (ready_i),
    .stall_i  (stall_i),
    .flush_i  (flush_i),
    .bubble_i (1'b0),
    .valid_o  (valid_o),
    .ready_o  (ready_o),
    .advance_o(advance)
  );

  // Result only moves when the controller advances,
  // so stall and back-pressure keep it stable
  always_ff @(posedge clk) begin
    if (advance) begin
      res_q <= alu_res;
    end
  end

  assign res_o = res_q;

endmodule

`default_nettype wire

// File: hdl/op_decode.sv
`default_nettype none

// Decode stage
// Turns either operation form into opcode plus two operands
module op_decode #(
  parameter bit DECODE_REG = 1'b1
) (
  input  wire                      clk,
  input  wire                      rst_i,

  input  wire alu_pipe_pkg::op_word_u op_i,
  input  wire                      valid_i,
  output logic                     ready_o,

  output alu_pipe_pkg::dec_ops_s   dec_o,
  output logic                     valid_o,
  input  wire                      ready_i,

  input  wire                      flush_i,
  input  wire                      bubble_i
);

  localparam int DATA_W = alu_pipe_pkg::DATA_W;
  localparam int IMM_W  = alu_pipe_pkg::IMM_W;

  alu_pipe_pkg::dec_ops_s dec_next;
  logic [DATA_W-1:0]      imm_ext;
  logic                   advance;

  // Sign extend the immediate to the full operand width
  assign imm_ext = {{(DATA_W - IMM_W){op_i.ri.imm[IMM_W-1]}}, op_i.ri.imm};

  always_comb begin
    // Opcode and a sit at the same place in both views
    dec_next.opcode = op_i.rr.opcode;
    dec_next.a      = op_i.rr.a;
    if (op_i.rr.form) begin
      // Low bits only, bits shifted past the top are dropped
      dec_next.b = imm_ext << op_i.ri.ishift;
    end else begin
      dec_next.b = op_i.rr.b;
    end
  end

  // Decode has no external stall, only bubble and back-pressure
  pipe_ctrl #(
    .SLICE_REG(DECODE_REG)
  ) u_ctrl (
    .clk      (clk),
    .rst_i    (rst_i),
    .valid_i  (valid_i),
    .ready_i  (ready_i),
    .stall_i  (1'b0),
    .flush_i  (flush_i),
    .bubble_i (bubble_i),
    .valid_o  (valid_o),
    .ready_o  (ready_o),
    .advance_o(advance)
  );

  generate
    if (DECODE_REG) begin : g_reg
      alu_pipe_pkg::dec_ops_s dec_q;

      always_ff @(posedge clk) begin
        if (advance) begin
          dec_q <= dec_next;
        end
      end

      assign dec_o = dec_q;
    end else begin : g_comb
      assign dec_o = dec_next;
    end
  endgenerate

endmodule

`default_nettype wire

// File: hdl/pipe_ctrl.sv
`default_nettype none

// Valid/ready controller for one pipeline stage
// Downstream back-pressure is folded into the stage stall
module pipe_ctrl #(
  parameter bit SLICE_REG = 1'b1
) (
  input  wire  clk,
  input  wire  rst_i,

  input  wire  valid_i,
  input  wire  ready_i,
  input  wire  stall_i,
  input  wire  flush_i,
  input  wire  bubble_i,

  output logic valid_o,
  output logic ready_o,
  output logic advance_o
);

  generate
    if (SLICE_REG) begin : g_reg
      logic valid_q;
      logic stall;
      logic go;

      // A held item that is not taken blocks the stage
      assign stall = stall_i || (valid_q && !ready_i);

      // Stage loads only when nothing holds it back
      assign go = !flush_i && !stall && !bubble_i;

      always_ff @(posedge clk) begin
        if (rst_i) begin
          valid_q <= 1'b0;
        end else if (flush_i) begin
          valid_q <= 1'b0;
        end else if (!stall) begin
          // A bubble inserts an empty slot
          valid_q <= valid_i && !bubble_i;
        end
      end

      assign valid_o   = valid_q;
      assign ready_o   = go;
      assign advance_o = go;
    end else begin : g_comb
      logic go;

      // No state here, the downstream stage sees the item in the same cycle
      assign go = !flush_i && !stall_i && !bubble_i;

      assign valid_o   = valid_i && go;
      assign ready_o   = ready_i && go;
      assign advance_o = ready_i && go;
    end
  endgenerate

endmodule

`default_nettype wire

// File: common/alu_pipe_pkg.sv
`default_nettype none

package alu_pipe_pkg;

  // Operand and result width of the datapath
  localparam int DATA_W = 16;

  // Width of the signed immediate in the immediate form
  localparam int IMM_W = 12;

  // Width of the immediate shift field
  localparam int ISHIFT_W = 4;

  // ALU operations, encoded in three bits
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_SLL = 3'd5,
    OP_SRL = 3'd6,
    OP_SLT = 3'd7
  } alu_opcode_e;

  // Register form, form bit is 0
  typedef struct packed {
    logic              form;
    alu_opcode_e       opcode;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
  } rr_op_s;

  // Immediate form, form bit is 1
  // Operand b is built from a shifted, sign extended immediate
  typedef struct packed {
    logic                form;
    alu_opcode_e         opcode;
    logic [DATA_W-1:0]   a;
    logic [ISHIFT_W-1:0] ishift;
    logic [IMM_W-1:0]    imm;
  } ri_op_s;

  // One 36-bit operation word, read through either view
  // The form bit is the MSB in both views
  typedef union packed {
    rr_op_s rr;
    ri_op_s ri;
  } op_word_u;

  // Operands after decode, handed to the execute stage
  typedef struct packed {
    alu_opcode_e       opcode;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
  } dec_ops_s;

endpackage

`default_nettype wire
